// File: hw/fpu_pkg.sv
// binary32 only; sub-operation rides in the rounding-mode field; only NV can ever be raised.
package fpu_pkg;

  localparam int unsigned FLEN     = 32;
  localparam int unsigned TAG_W    = 6;
  localparam int unsigned STATUS_W = 5; // {NV, DZ, OF, UF, NX}.

  typedef enum logic [1:0] {
    SGNJ,
    MINMAX,
    CMP,
    CLASSIFY
  } fp_op_e;

  // sub-operation select, named after the rounding modes.
  //   SGNJ:   RNE plain, RTZ negated, RDN xor
  //   MINMAX: RNE min, RTZ max
  //   CMP:    RNE le, RTZ lt, RDN eq
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } fp_rm_e;

  localparam logic [FLEN-1:0] CANON_NAN = 32'h7FC0_0000;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_fields_t;

  // one word, seen as raw bits or as its IEEE fields.
  typedef union packed {
    logic [FLEN-1:0] bits;
    fp32_fields_t    fields;
  } fp32_u;

  // risc-v class mask, bit 0 is negative infinity.
  typedef struct packed {
    logic qnan;
    logic snan;
    logic pos_inf;
    logic pos_norm;
    logic pos_sub;
    logic pos_zero;
    logic neg_zero;
    logic neg_sub;
    logic neg_norm;
    logic neg_inf;
  } fp_class_t;

  typedef struct packed {
    fp32_u [1:0]      operands;
    fp_op_e           op;
    fp_rm_e           rnd_mode;
    logic [TAG_W-1:0] tag;
  } fpu_req_t;

  typedef struct packed {
    logic [FLEN-1:0]     result;
    logic [STATUS_W-1:0] status;
    logic [TAG_W-1:0]    tag;
  } fpu_rsp_t;

endpackage

// File: hw/spill_register.sv
// data registers are not reset; with Bypass set the slice is combinational and adds no latency.
module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    T     a_data_q;
    T     b_data_q;
    logic a_full_q;
    logic b_full_q;
    logic a_fill;
    logic a_drain;
    logic b_fill;
    logic b_drain;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q; // a empties, to the output or into b.
    assign b_fill  = a_drain && !ready_i;   // stalled, so park a's item in b.
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // ready only looks at the fill flags.
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q; // b always holds the older item.

    assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o))
      else $error("spill_register: output changed while stalled");
  end

endmodule

// File: hw/fp_classify.sv
// combinational binary32 classifier; a NaN with mantissa bit 22 clear is signaling.
module fp_classify (
  input  fpu_pkg::fp32_u     value_i,
  output fpu_pkg::fp_class_t class_o,
  output logic               is_nan_o,
  output logic               is_snan_o
);

  logic sign;
  logic quiet;
  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  assign sign     = value_i.fields.sign;
  assign quiet    = value_i.fields.mantissa[22];
  assign exp_zero = (value_i.fields.exponent == '0);
  assign exp_ones = (value_i.fields.exponent == '1);
  assign man_zero = (value_i.fields.mantissa == '0);

  always_comb begin
    class_o = '0;
    if (exp_ones && !man_zero) begin
      class_o.qnan = quiet;
      class_o.snan = !quiet;
    end else if (exp_ones) begin
      class_o.pos_inf = !sign;
      class_o.neg_inf = sign;
    end else if (exp_zero && man_zero) begin
      class_o.pos_zero = !sign;
      class_o.neg_zero = sign;
    end else if (exp_zero) begin // denormal.
      class_o.pos_sub = !sign;
      class_o.neg_sub = sign;
    end else begin
      class_o.pos_norm = !sign;
      class_o.neg_norm = sign;
    end
  end

  assign is_nan_o  = exp_ones && !man_zero;
  assign is_snan_o = is_nan_o && !quiet;

  // exactly one class per known input.
  always_comb begin
    if (!$isunknown(value_i)) begin
      assert final ($onehot(class_o))
        else $error("fp_classify: class mask %b not one-hot for %h", class_o, value_i);
    end
  end

endmodule

// File: hw/fpu_noncomp.sv
// one-stage non-computational binary32 unit; an illegal sub-op gives zero, or the minimum for min/max.
module fpu_noncomp (
  input  logic              clk_i,
  input  logic              rst_i,
  input  fpu_pkg::fpu_req_t req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output fpu_pkg::fpu_rsp_t rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  fpu_pkg::fp32_u           opa;
  fpu_pkg::fp32_u           opb;
  fpu_pkg::fp_class_t       cls_a;
  fpu_pkg::fp_class_t       cls_b;
  logic [fpu_pkg::FLEN-2:0] mag_a;
  logic [fpu_pkg::FLEN-2:0] mag_b;
  logic                     nan_a;
  logic                     nan_b;
  logic                     snan_a;
  logic                     snan_b;
  logic                     any_nan;
  logic                     any_snan;
  logic                     both_zero;
  logic                     lt_total;
  logic                     lt_ieee;
  logic                     eq_ieee;
  logic [fpu_pkg::FLEN-1:0] result;
  logic                     nv;
  logic                     rm_legal;
  logic                     valid_q;
  fpu_pkg::fpu_rsp_t        rsp_q;

  assign opa   = req_i.operands[0];
  assign opb   = req_i.operands[1];
  assign mag_a = opa.bits[fpu_pkg::FLEN-2:0];
  assign mag_b = opb.bits[fpu_pkg::FLEN-2:0];

  fp_classify u_class_a (
    .value_i   ( opa    ),
    .class_o   ( cls_a  ),
    .is_nan_o  ( nan_a  ),
    .is_snan_o ( snan_a )
  );

  fp_classify u_class_b (
    .value_i   ( opb    ),
    .class_o   ( cls_b  ),
    .is_nan_o  ( nan_b  ),
    .is_snan_o ( snan_b )
  );

  assign any_nan   = nan_a || nan_b;
  assign any_snan  = snan_a || snan_b;
  assign both_zero = (cls_a.pos_zero || cls_a.neg_zero) && (cls_b.pos_zero || cls_b.neg_zero);

  // sign-magnitude order, -0 sorts below +0.
  always_comb begin
    if (opa.fields.sign != opb.fields.sign) begin
      lt_total = opa.fields.sign;
    end else if (opa.fields.sign) begin
      lt_total = mag_a > mag_b;
    end else begin
      lt_total = mag_a < mag_b;
    end
  end

  assign eq_ieee = (opa.bits == opb.bits) || both_zero; // +0 == -0 for compares.
  assign lt_ieee = lt_total && !both_zero;

  always_comb begin
    result = '0;
    nv     = 1'b0;
    case (req_i.op)
      fpu_pkg::SGNJ: begin
        case (req_i.rnd_mode)
          fpu_pkg::RNE: result = {opb.fields.sign, mag_a};
          fpu_pkg::RTZ: result = {!opb.fields.sign, mag_a};
          fpu_pkg::RDN: result = {opa.fields.sign ^ opb.fields.sign, mag_a};
          default:      result = '0;
        endcase
      end
      fpu_pkg::MINMAX: begin
        nv = any_snan;
        if (nan_a && nan_b) begin
          result = fpu_pkg::CANON_NAN;
        end else if (nan_a) begin
          result = opb.bits;
        end else if (nan_b) begin
          result = opa.bits;
        end else if (req_i.rnd_mode == fpu_pkg::RTZ) begin // max.
          result = lt_total ? opb.bits : opa.bits;
        end else begin
          result = lt_total ? opa.bits : opb.bits;
        end
      end
      fpu_pkg::CMP: begin
        case (req_i.rnd_mode)
          fpu_pkg::RNE: begin
            result[0] = (lt_ieee || eq_ieee) && !any_nan;
            nv        = any_nan;
          end
          fpu_pkg::RTZ: begin
            result[0] = lt_ieee && !any_nan;
            nv        = any_nan;
          end
          fpu_pkg::RDN: begin
            result[0] = eq_ieee && !any_nan;
            nv        = any_snan; // quiet compare.
          end
          default: result = '0;
        endcase
      end
      fpu_pkg::CLASSIFY: result = fpu_pkg::FLEN'(cls_a);
      default:           result = '0;
    endcase
  end

  always_comb begin
    case (req_i.op)
      fpu_pkg::MINMAX:   rm_legal = req_i.rnd_mode inside {fpu_pkg::RNE, fpu_pkg::RTZ};
      fpu_pkg::CLASSIFY: rm_legal = 1'b1;
      default:           rm_legal = req_i.rnd_mode inside {fpu_pkg::RNE, fpu_pkg::RTZ, fpu_pkg::RDN};
    endcase
  end

  // stage is free when empty or when its result leaves this cycle.
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_ready_o) begin
      rsp_q.result <= result;
      rsp_q.status <= {nv, {(fpu_pkg::STATUS_W-1){1'b0}}};
      rsp_q.tag    <= req_i.tag;
    end
  end

  assign out_valid_o = valid_q;
  assign rsp_o       = rsp_q;

  assert property (@(posedge clk_i) disable iff (rst_i) in_valid_i && in_ready_o |-> rm_legal)
    else $error("fpu_noncomp: sub-op %0d illegal for op %0d", req_i.rnd_mode, req_i.op);

endmodule

// File: hw/fpu_wrap.sv
// three-cycle latency with spill registers, one with Bypass; results stall while out_ready_i is low.
module fpu_wrap #(
  parameter bit Bypass = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  fpu_pkg::fp32_u [1:0]         operands_i,
  input  fpu_pkg::fp_op_e              op_i,
  input  fpu_pkg::fp_rm_e              rnd_mode_i,
  input  logic [fpu_pkg::TAG_W-1:0]    tag_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  output logic [fpu_pkg::FLEN-1:0]     result_o,
  output logic [fpu_pkg::STATUS_W-1:0] status_o,
  output logic [fpu_pkg::TAG_W-1:0]    tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i
);

  fpu_pkg::fpu_req_t req;
  fpu_pkg::fpu_req_t req_q;
  fpu_pkg::fpu_rsp_t rsp;
  fpu_pkg::fpu_rsp_t rsp_q;
  logic              req_valid_q;
  logic              req_ready_q;
  logic              rsp_valid;
  logic              rsp_ready;

  assign req = '{
    operands: operands_i,
    op:       op_i,
    rnd_mode: rnd_mode_i,
    tag:      tag_i
  };

  spill_register #(
    .T      ( fpu_pkg::fpu_req_t ),
    .Bypass ( Bypass             )
  ) u_spill_in (
    .clk_i,
    .rst_i,
    .valid_i ( in_valid_i  ),
    .ready_o ( in_ready_o  ),
    .data_i  ( req         ),
    .valid_o ( req_valid_q ),
    .ready_i ( req_ready_q ),
    .data_o  ( req_q       )
  );

  fpu_noncomp u_noncomp (
    .clk_i,
    .rst_i,
    .req_i       ( req_q       ),
    .in_valid_i  ( req_valid_q ),
    .in_ready_o  ( req_ready_q ),
    .rsp_o       ( rsp         ),
    .out_valid_o ( rsp_valid   ),
    .out_ready_i ( rsp_ready   )
  );

  spill_register #(
    .T      ( fpu_pkg::fpu_rsp_t ),
    .Bypass ( Bypass             )
  ) u_spill_out (
    .clk_i,
    .rst_i,
    .valid_i ( rsp_valid   ),
    .ready_o ( rsp_ready   ),
    .data_i  ( rsp         ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .data_o  ( rsp_q       )
  );

  assign result_o = rsp_q.result;
  assign status_o = rsp_q.status;
  assign tag_o    = rsp_q.tag;

endmodule

// File: bench/fpu_ref_model.svh
// included inside the testbench module; needs fpu_pkg compiled first and models binary32 only.
`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

// right-shifting galois form, taps x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// one-hot risc-v class mask, bit 0 is negative infinity.
function automatic logic [9:0] ref_class(input logic [31:0] x);
  int idx;
  if (&x[30:23]) begin
    idx = (x[22:0] == 0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
  end else if (x[30:23] == 0) begin
    idx = (x[22:0] == 0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
  end else begin
    idx = x[31] ? 1 : 6;
  end
  return 10'b1 << idx;
endfunction

// maps sign-magnitude onto an unsigned order, -0 lands just below +0.
function automatic logic [31:0] order_key(input logic [31:0] x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic fpu_pkg::fpu_rsp_t ref_rsp(input logic [31:0] a, input logic [31:0] b,
                                              input fpu_pkg::fp_op_e op,
                                              input fpu_pkg::fp_rm_e rm,
                                              input logic [5:0] tag);
  fpu_pkg::fpu_rsp_t r;
  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic zeros;
  logic lt;
  logic eq;
  logic sgn;
  a_nan  = (&a[30:23]) && (a[22:0] != 0);
  b_nan  = (&b[30:23]) && (b[22:0] != 0);
  a_snan = a_nan && !a[22];
  b_snan = b_nan && !b[22];
  zeros  = (a[30:0] == 0) && (b[30:0] == 0);
  lt     = (order_key(a) < order_key(b)) && !zeros;
  eq     = (a == b) || zeros;
  r      = '{result: '0, status: '0, tag: tag};
  case (op)
    fpu_pkg::SGNJ: begin
      sgn = (rm == fpu_pkg::RTZ) ? !b[31] : ((rm == fpu_pkg::RDN) ? a[31] ^ b[31] : b[31]);
      r.result = {sgn, a[30:0]};
    end
    fpu_pkg::MINMAX: begin
      r.status[4] = a_snan || b_snan;
      if (a_nan && b_nan) begin
        r.result = fpu_pkg::CANON_NAN;
      end else if (a_nan) begin
        r.result = b;
      end else if (b_nan) begin
        r.result = a;
      end else begin
        r.result = ((order_key(a) < order_key(b)) == (rm == fpu_pkg::RNE)) ? a : b;
      end
    end
    fpu_pkg::CMP: begin
      r.status[4] = (rm == fpu_pkg::RDN) ? (a_snan || b_snan) : (a_nan || b_nan); // eq is quiet.
      r.result[0] = !(a_nan || b_nan) &&
                    ((rm == fpu_pkg::RDN) ? eq : ((rm == fpu_pkg::RTZ) ? lt : (lt || eq)));
    end
    default: r.result = {22'b0, ref_class(a)};
  endcase
  return r;
endfunction

`endif

// File: bench/tb_fpu_wrap.sv
// drives fpu_wrap with spill registers on; needs a simulator with concurrent assertion support.
module tb_fpu_wrap;

  localparam int NUM_TESTS   = 400;
  localparam int LAT_TESTS   = 8;
  localparam int CYCLE_LIMIT = NUM_TESTS * 3 * 4 + 100;
  localparam int DRAIN_LIMIT = 20; // five in flight plus the pipeline, with margin.
  localparam logic [31:0] SEED = 32'h7b1b_7c08;
  localparam int G_RESET  = 0;
  localparam int G_SGNJ   = 1;
  localparam int G_MINMAX = 2;
  localparam int G_CMP    = 3;
  localparam int G_ORDER  = 4;
  localparam int G_LAT    = 5;
  // +-0, +-inf, quiet nan, signaling nan, +-denormal, +-1.0.
  localparam logic [9:0][31:0] SPECIALS = {
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000,
    32'h7fa0_0000, 32'h0040_0000, 32'h8000_0001, 32'h3f80_0000, 32'hbf80_0000
  };

  typedef struct packed {
    fpu_pkg::fpu_rsp_t rsp;
    fpu_pkg::fp_op_e   op;
  } exp_entry_t;

  `include "fpu_ref_model.svh"

  logic                 clk_i;
  logic                 rst_i;
  fpu_pkg::fp32_u [1:0] operands_i;
  fpu_pkg::fp_op_e      op_i;
  fpu_pkg::fp_rm_e      rnd_mode_i;
  logic [5:0]           tag_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic [31:0]          result_o;
  logic [4:0]           status_o;
  logic [5:0]           tag_o;
  logic                 out_valid_o;
  logic                 out_ready_i;

  logic [31:0] lfsr_state;
  logic [5:0]  next_tag;
  exp_entry_t  exp_q[$];
  exp_entry_t  exp_head;
  logic        exp_valid = 1'b0;
  int          exp_grp = G_SGNJ;
  logic        stalled_q = 1'b0;
  logic [42:0] held_q;
  logic        lat_phase = 1'b0;
  logic        timed_out = 1'b0;
  logic [9:0]  class_seen = '0;
  logic [2:0]  sgnj_seen = '0;
  int          cycles = 0;
  int          accepted = 0;
  int          responses = 0;
  int          stall_checks = 0;
  int          lat_checks = 0;
  int          group_checks[6] = '{default: 0};
  int          group_errors[6] = '{default: 0};

  fpu_wrap #(
    .Bypass ( 1'b0 )
  ) dut (
    .clk_i, .rst_i, .operands_i, .op_i, .rnd_mode_i, .tag_i, .in_valid_i, .in_ready_o,
    .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
  end

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [3:0] idx;
    if (draw_bits(2) == 0) begin
      return draw_bits(32);
    end
    idx = draw_bits(4);
    return SPECIALS[idx % 10];
  endfunction

  function automatic int group_of(input fpu_pkg::fp_op_e op);
    case (op)
      fpu_pkg::MINMAX: return G_MINMAX;
      fpu_pkg::CMP:    return G_CMP;
      default:         return G_SGNJ;
    endcase
  endfunction

  task automatic new_request();
    fpu_pkg::fp_op_e op;
    fpu_pkg::fp_rm_e rm;
    logic [1:0]      r;
    op = fpu_pkg::fp_op_e'(draw_bits(2));
    r  = draw_bits(2);
    case (op)
      fpu_pkg::MINMAX:   rm = fpu_pkg::fp_rm_e'({2'b0, r[0]});
      fpu_pkg::CLASSIFY: rm = fpu_pkg::fp_rm_e'({1'b0, r}); // ignored by classify.
      default:           rm = (r == 2'd3) ? fpu_pkg::RNE : fpu_pkg::fp_rm_e'({1'b0, r});
    endcase
    operands_i[0].bits <= pick_operand();
    operands_i[1].bits <= pick_operand();
    op_i       <= op;
    rnd_mode_i <= rm;
    tag_i      <= next_tag;
    in_valid_i <= 1'b1;
    next_tag = next_tag + 1;
  endtask

  task automatic value_mismatch(input int grp, input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("Fail %s expected %0h got %0h", name, expected, actual);
    group_errors[grp]++;
  endtask

  task automatic rsp_mismatch(input int grp, input fpu_pkg::fpu_rsp_t got,
                              input fpu_pkg::fpu_rsp_t expected);
    if (got.result !== expected.result) begin
      value_mismatch(grp, "result_o", expected.result, got.result);
    end
    if (got.status !== expected.status) begin
      value_mismatch(grp, "status_o", expected.status, got.status);
    end
    if (got.tag !== expected.tag) begin
      value_mismatch(grp, "tag_o", expected.tag, got.tag);
    end
  endtask

  task automatic plain_failure(input int grp, input string what);
    $display("%s", what);
    group_errors[grp]++;
  endtask

  task automatic finish_run();
    int total;
    total = 0;
    foreach (group_errors[g]) begin
      total += group_errors[g];
    end
    $display("summary: %0d requests, %0d responses, %0d errors, %0d cycles",
             accepted, responses, total, cycles);
    if (total == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // scoreboard, the head is republished each edge for the assertions.
  always @(posedge clk_i) begin
    exp_entry_t e;
    if (!rst_i) begin
      if (out_valid_o && out_ready_i && exp_q.size() > 0) begin
        e = exp_q.pop_front();
        responses++;
        group_checks[group_of(e.op)]++;
      end
      if (in_valid_i && in_ready_o) begin
        e.op  = op_i;
        e.rsp = ref_rsp(operands_i[0].bits, operands_i[1].bits, op_i, rnd_mode_i, tag_i);
        exp_q.push_back(e);
        accepted++;
        if (lat_phase) begin
          lat_checks++;
        end
        if (op_i == fpu_pkg::CLASSIFY) begin
          class_seen |= e.rsp.result[9:0];
        end
        if (op_i == fpu_pkg::SGNJ) begin
          sgnj_seen[int'(rnd_mode_i)] = 1'b1;
        end
      end
      if (out_valid_o && !out_ready_i) begin
        stall_checks++;
      end
    end
    stalled_q <= !rst_i && out_valid_o && !out_ready_i;
    held_q    <= {result_o, status_o, tag_o};
    exp_valid <= exp_q.size() > 0;
    if (exp_q.size() > 0) begin
      exp_head <= exp_q[0];
      exp_grp  <= group_of(exp_q[0].op);
    end
  end

  assert property (@(posedge clk_i) rst_i ##1 rst_i |-> !out_valid_o)
    else value_mismatch(G_RESET, "out_valid_o", 0, $sampled(out_valid_o));

  assert property (@(posedge clk_i) $fell(rst_i) |-> !out_valid_o && in_ready_o)
    else value_mismatch(G_RESET, "{out_valid_o,in_ready_o}", 2'b01,
                        {$sampled(out_valid_o), $sampled(in_ready_o)});

  assert property (@(posedge clk_i) disable iff (rst_i) out_valid_o && out_ready_i |-> exp_valid)
    else plain_failure(G_ORDER, $sformatf("a response with tag %0h arrived with none outstanding",
                                          $sampled(tag_o)));

  assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i && exp_valid && exp_grp == G_SGNJ
    |-> {result_o, status_o, tag_o} == exp_head.rsp)
    else rsp_mismatch(G_SGNJ, $sampled({result_o, status_o, tag_o}), $sampled(exp_head.rsp));

  assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i && exp_valid && exp_grp == G_MINMAX
    |-> {result_o, status_o, tag_o} == exp_head.rsp)
    else rsp_mismatch(G_MINMAX, $sampled({result_o, status_o, tag_o}), $sampled(exp_head.rsp));

  assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i && exp_valid && exp_grp == G_CMP
    |-> {result_o, status_o, tag_o} == exp_head.rsp)
    else rsp_mismatch(G_CMP, $sampled({result_o, status_o, tag_o}), $sampled(exp_head.rsp));

  // a stalled result must not move.
  assert property (@(posedge clk_i) disable iff (rst_i)
    stalled_q |-> out_valid_o && {result_o, status_o, tag_o} == held_q)
    else value_mismatch(G_ORDER, "{out_valid_o,result_o,status_o,tag_o}", {1'b1, held_q},
                        $sampled({out_valid_o, result_o, status_o, tag_o}));

  assert property (@(posedge clk_i) disable iff (rst_i)
    lat_phase && in_valid_i && in_ready_o |-> ##1 !out_valid_o ##1 !out_valid_o ##1 out_valid_o)
    else plain_failure(G_LAT, "out_valid_o did not rise exactly three cycles after acceptance");

  initial begin
    wait (cycles >= CYCLE_LIMIT);
    timed_out = 1'b1;
    $display("timeout after %0d cycles with %0d responses outstanding", cycles, exp_q.size());
    finish_run();
  end

  initial begin
    int sent;
    int issued;
    int drain;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    operands_i  = '0;
    op_i        = fpu_pkg::SGNJ;
    rnd_mode_i  = fpu_pkg::RNE;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    lfsr_state  = SEED;
    next_tag    = '0;
    sent        = 0;
    issued      = 0;
    drain       = 0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    $display("reset: out_valid_o low, in_ready_o high on release, errors %0d",
             group_errors[G_RESET]);

    // random traffic with random stalls on both sides.
    while (sent < NUM_TESTS) begin
      @(posedge clk_i);
      if (in_valid_i && in_ready_o) begin
        sent++;
        in_valid_i <= 1'b0;
      end
      if ((!in_valid_i || in_ready_o) && issued < NUM_TESTS && draw_bits(2) != 0) begin
        new_request();
        issued++;
      end
      out_ready_i <= draw_bits(2) != 0;
    end
    out_ready_i <= 1'b1;
    do begin
      @(posedge clk_i);
      drain++;
    end while (exp_valid && drain < DRAIN_LIMIT);
    repeat (3) @(posedge clk_i);
    assert (responses == accepted)
      else plain_failure(G_ORDER, $sformatf("%0d of %0d responses came back",
                                            responses, accepted));
    assert (class_seen == 10'h3ff)
      else plain_failure(G_SGNJ, $sformatf("classify only saw classes %b", class_seen));
    assert (sgnj_seen == 3'b111)
      else plain_failure(G_SGNJ, "not every sign-injection variant was sent");
    assert (group_checks[G_MINMAX] > 0 && group_checks[G_CMP] > 0)
      else plain_failure(G_ORDER, "min/max or compare was never exercised");
    $display("sign injection and classify: %0d responses, errors %0d",
             group_checks[G_SGNJ], group_errors[G_SGNJ]);
    $display("min/max: %0d responses, errors %0d", group_checks[G_MINMAX],
             group_errors[G_MINMAX]);
    $display("compare: %0d responses, errors %0d", group_checks[G_CMP], group_errors[G_CMP]);
    $display("back-pressure and ordering: %0d stalled cycles, %0d of %0d back, errors %0d",
             stall_checks, responses, accepted, group_errors[G_ORDER]);

    lat_phase <= 1'b1;
    repeat (LAT_TESTS) begin
      new_request();
      do @(posedge clk_i); while (!in_ready_o);
      in_valid_i <= 1'b0;
      do @(posedge clk_i); while (exp_valid); // pipeline empty again.
    end
    repeat (2) @(posedge clk_i);
    $display("latency: %0d single requests, errors %0d", lat_checks, group_errors[G_LAT]);
    finish_run();
  end

endmodule

// File: verilog.f
+incdir+bench
hw/fpu_pkg.sv
hw/spill_register.sv
hw/fp_classify.sv
hw/fpu_noncomp.sv
hw/fpu_wrap.sv
bench/tb_fpu_wrap.sv
